//--- include/timer_defs.svh
/*
 * Address map, bus widths and reset values for the timer subsystem.
 * Slave select codes sit in address bits 3:2, register selects in 1:0.
 */

`ifndef TIMER_DEFS_SVH
`define TIMER_DEFS_SVH

// ---------------------------------------------------------------------------
// peripheral bus widths
// ---------------------------------------------------------------------------
`define WB_ADR_WIDTH 4
`define WB_DAT_WIDTH 32
`define WB_SEL_WIDTH 4

// ---------------------------------------------------------------------------
// slave select codes, adr[3:2]
// ---------------------------------------------------------------------------
`define SLV_TIMER0 2'd0
`define SLV_TIMER1 2'd1
`define SLV_IRQ    2'd2
// code 3 is unmapped, answered by the decoder

// timer compare value after reset, 50000 cycle period
`define TIMER_COMPARE_RESET 32'd49999

// interrupt controller inputs, one per timer
`define IRQ_SOURCES 2

`endif

//--- hw/timer_pkg.sv
/*
 * Shared types for the timer subsystem.
 * Bus request and response structs, register select enums
 * and the arbiter state encoding.
 */

package timer_pkg;

`include "timer_defs.svh"

	// ---------------------------------------------------------------------------
	// peripheral bus
	// ---------------------------------------------------------------------------
	typedef struct packed {
		logic [`WB_ADR_WIDTH-1:0] adr;
		logic [`WB_DAT_WIDTH-1:0] dat;
		logic                     we;
		logic [`WB_SEL_WIDTH-1:0] sel;
		logic                     stb;
	} wb_req_t;

	typedef struct packed {
		logic [`WB_DAT_WIDTH-1:0] dat;
		logic                     ack;
	} wb_rsp_t;

	// timer registers, select 2 reads as zero
	typedef enum logic [1:0] {
		CONTROL = 2'd0,
		COMPARE = 2'd1,
		COUNTER = 2'd3
	} timer_reg_e;

	// interrupt controller registers
	typedef enum logic [1:0] {
		PENDING = 2'd0,
		ENABLE  = 2'd1
	} irq_reg_e;

	typedef enum logic [1:0] {
		GRANT_IDLE  = 2'd0,
		GRANT_HOST0 = 2'd1,
		GRANT_HOST1 = 2'd2
	} grant_e;

endpackage

//--- hw/wb_arbiter.sv
/*
 * Round-robin arbiter for two host ports on one peripheral bus.
 * The grant is held for one single-beat transfer and released on ack.
 */

`timescale 1ns/100ps

module wb_arbiter
	import timer_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  wb_req_t host0_req_i,
	input  wb_req_t host1_req_i,
	output wb_rsp_t host0_rsp_o,
	output wb_rsp_t host1_rsp_o,
	output wb_req_t bus_req_o,
	input  wb_rsp_t bus_rsp_i
);

	grant_e grant_state;
	// set when host 1 owned the last finished transfer
	logic   last_host1;

	// ---------------------------------------------------------------------------
	// grant state
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			grant_state <= GRANT_IDLE;
			last_host1  <= 1'b0;
		end else begin
			case (grant_state)
				GRANT_IDLE: begin
					if (host0_req_i.stb && host1_req_i.stb) begin
						// tie goes to the host not served last
						grant_state <= last_host1 ? GRANT_HOST0 : GRANT_HOST1;
					end else if (host0_req_i.stb) begin
						grant_state <= GRANT_HOST0;
					end else if (host1_req_i.stb) begin
						grant_state <= GRANT_HOST1;
					end
				end
				GRANT_HOST0: begin
					if (bus_rsp_i.ack) begin
						grant_state <= GRANT_IDLE;
						last_host1  <= 1'b0;
					end
				end
				GRANT_HOST1: begin
					if (bus_rsp_i.ack) begin
						grant_state <= GRANT_IDLE;
						last_host1  <= 1'b1;
					end
				end
				default: grant_state <= GRANT_IDLE;
			endcase
		end
	end

	// ---------------------------------------------------------------------------
	// request mux and response steering
	// ---------------------------------------------------------------------------
	always_comb begin
		bus_req_o       = '0;
		host0_rsp_o.dat = bus_rsp_i.dat;
		host0_rsp_o.ack = 1'b0;
		host1_rsp_o.dat = bus_rsp_i.dat;
		host1_rsp_o.ack = 1'b0;
		case (grant_state)
			GRANT_HOST0: begin
				bus_req_o       = host0_req_i;
				host0_rsp_o.ack = bus_rsp_i.ack;
			end
			GRANT_HOST1: begin
				bus_req_o       = host1_req_i;
				host1_rsp_o.ack = bus_rsp_i.ack;
			end
			// idle keeps the bus strobe low
			default: bus_req_o = '0;
		endcase
	end

endmodule

//--- hw/periph_decoder.sv
/*
 * Address decoder for the peripheral bus.
 * Routes the strobe to one slave and muxes its response back;
 * the unmapped code is answered here with zero data.
 */

`timescale 1ns/100ps

`include "timer_defs.svh"

module periph_decoder
	import timer_pkg::*;
(
	input  wb_req_t bus_req_i,
	output wb_rsp_t bus_rsp_o,
	output wb_req_t tmr0_req_o,
	output wb_req_t tmr1_req_o,
	output wb_req_t irq_req_o,
	input  wb_rsp_t tmr0_rsp_i,
	input  wb_rsp_t tmr1_rsp_i,
	input  wb_rsp_t irq_rsp_i
);

	logic [1:0] slave_sel;

	assign slave_sel = bus_req_i.adr[3:2];

	// ---------------------------------------------------------------------------
	// request fan-out
	// ---------------------------------------------------------------------------
	always_comb begin
		tmr0_req_o     = bus_req_i;
		tmr1_req_o     = bus_req_i;
		irq_req_o      = bus_req_i;
		// only the addressed slave sees its strobe
		tmr0_req_o.stb = bus_req_i.stb && (slave_sel == `SLV_TIMER0);
		tmr1_req_o.stb = bus_req_i.stb && (slave_sel == `SLV_TIMER1);
		irq_req_o.stb  = bus_req_i.stb && (slave_sel == `SLV_IRQ);
	end

	// ---------------------------------------------------------------------------
	// response mux
	// ---------------------------------------------------------------------------
	always_comb begin
		case (slave_sel)
			`SLV_TIMER0: begin
				bus_rsp_o = tmr0_rsp_i;
			end
			`SLV_TIMER1: begin
				bus_rsp_o = tmr1_rsp_i;
			end
			`SLV_IRQ: begin
				bus_rsp_o = irq_rsp_i;
			end
			default: begin
				// unmapped, ack locally so the master never hangs
				bus_rsp_o.dat = '0;
				bus_rsp_o.ack = bus_req_i.stb;
			end
		endcase
	end

endmodule

//--- hw/interval_timer.sv
/*
 * Compare-match interval timer.
 * Control register with enable and self-clearing clear bit,
 * compare register, free counter and a one-cycle interrupt pulse.
 */

`timescale 1ns/100ps

`include "timer_defs.svh"

module interval_timer
	import timer_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  wb_req_t bus_req_i,
	output wb_rsp_t bus_rsp_o,
	output logic    interrupt_req_o
);

	logic                     reg_enable;
	logic                     reg_clear;
	logic [`WB_DAT_WIDTH-1:0] reg_compare;
	logic [`WB_DAT_WIDTH-1:0] reg_counter;

	timer_reg_e reg_sel;
	logic       wr_en;
	logic       compare_match;

	assign reg_sel       = timer_reg_e'(bus_req_i.adr[1:0]);
	assign wr_en         = bus_req_i.stb && bus_req_i.we;
	assign compare_match = (reg_counter == reg_compare);

	// ---------------------------------------------------------------------------
	// registers
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_enable      <= 1'b0;
			reg_clear       <= 1'b0;
			reg_compare     <= `TIMER_COMPARE_RESET;
			reg_counter     <= '0;
			interrupt_req_o <= 1'b0;
		end else begin
			// clear drops again one cycle after a control write
			if (wr_en && (reg_sel == CONTROL)) begin
				reg_enable <= bus_req_i.dat[0];
				reg_clear  <= bus_req_i.dat[1];
			end else begin
				reg_clear <= 1'b0;
			end

			if (wr_en && (reg_sel == COMPARE)) begin
				reg_compare <= bus_req_i.dat;
			end

			// wrap on match or clear
			if (compare_match || reg_clear) begin
				reg_counter <= '0;
			end else if (reg_enable) begin
				reg_counter <= reg_counter + 1'b1;
			end

			// pulse only while enabled
			interrupt_req_o <= compare_match && reg_enable;
		end
	end

	// ---------------------------------------------------------------------------
	// read back
	// ---------------------------------------------------------------------------
	always_comb begin
		// single cycle slave
		bus_rsp_o.ack = bus_req_i.stb;
		case (reg_sel)
			CONTROL: bus_rsp_o.dat = {{(`WB_DAT_WIDTH-2){1'b0}}, reg_clear, reg_enable};
			COMPARE: bus_rsp_o.dat = reg_compare;
			COUNTER: bus_rsp_o.dat = reg_counter;
			default: bus_rsp_o.dat = '0;
		endcase
	end

endmodule

//--- hw/irq_controller.sv
/*
 * Interrupt controller with pending and enable registers.
 * Source pulses latch into pending; irq_o is the registered
 * OR of every pending bit that is also enabled.
 */

`timescale 1ns/100ps

`include "timer_defs.svh"

module irq_controller
	import timer_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic [`IRQ_SOURCES-1:0] src_pulse_i,
	input  wb_req_t                 bus_req_i,
	output wb_rsp_t                 bus_rsp_o,
	output logic                    irq_o
);

	logic [`IRQ_SOURCES-1:0] reg_pending;
	logic [`IRQ_SOURCES-1:0] reg_enable;
	logic [`IRQ_SOURCES-1:0] pending_clr;

	irq_reg_e reg_sel;
	logic     wr_en;

	assign reg_sel = irq_reg_e'(bus_req_i.adr[1:0]);
	assign wr_en   = bus_req_i.stb && bus_req_i.we;

	// write-one-to-clear mask
	assign pending_clr = (wr_en && (reg_sel == PENDING)) ?
		bus_req_i.dat[`IRQ_SOURCES-1:0] : '0;

	// ---------------------------------------------------------------------------
	// pending, enable and interrupt output
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_pending <= '0;
			reg_enable  <= '0;
			irq_o       <= 1'b0;
		end else begin
			// a new pulse beats a clear in the same cycle
			reg_pending <= (reg_pending & ~pending_clr) | src_pulse_i;

			if (wr_en && (reg_sel == ENABLE)) begin
				reg_enable <= bus_req_i.dat[`IRQ_SOURCES-1:0];
			end

			irq_o <= |(reg_pending & reg_enable);
		end
	end

	// ---------------------------------------------------------------------------
	// read back
	// ---------------------------------------------------------------------------
	always_comb begin
		bus_rsp_o.ack = bus_req_i.stb;
		bus_rsp_o.dat = '0;
		case (reg_sel)
			PENDING: bus_rsp_o.dat[`IRQ_SOURCES-1:0] = reg_pending;
			ENABLE:  bus_rsp_o.dat[`IRQ_SOURCES-1:0] = reg_enable;
			default: bus_rsp_o.dat = '0;
		endcase
	end

endmodule

//--- hw/timer_subsys_top.sv
/*
 * Timer subsystem top level.
 * Two host ports, round-robin arbiter, address decoder,
 * two interval timers and the interrupt controller.
 */

`timescale 1ns/100ps

`include "timer_defs.svh"

module timer_subsys_top
	import timer_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  wb_req_t host0_req_i,
	input  wb_req_t host1_req_i,
	output wb_rsp_t host0_rsp_o,
	output wb_rsp_t host1_rsp_o,
	output logic    irq_o
);

	// shared bus between arbiter and decoder
	wb_req_t bus_req;
	wb_rsp_t bus_rsp;

	// per slave
	wb_req_t tmr0_req;
	wb_rsp_t tmr0_rsp;
	wb_req_t tmr1_req;
	wb_rsp_t tmr1_rsp;
	wb_req_t irq_req;
	wb_rsp_t irq_rsp;

	// timer pulses, bit n from timer n
	logic [`IRQ_SOURCES-1:0] tmr_irq;

	// ---------------------------------------------------------------------------
	// bus fabric
	// ---------------------------------------------------------------------------
	wb_arbiter wb_arbiter_inst (
		.clk         (clk),
		.reset       (reset),
		.host0_req_i (host0_req_i),
		.host1_req_i (host1_req_i),
		.host0_rsp_o (host0_rsp_o),
		.host1_rsp_o (host1_rsp_o),
		.bus_req_o   (bus_req),
		.bus_rsp_i   (bus_rsp)
	);

	periph_decoder periph_decoder_inst (
		.bus_req_i  (bus_req),
		.bus_rsp_o  (bus_rsp),
		.tmr0_req_o (tmr0_req),
		.tmr1_req_o (tmr1_req),
		.irq_req_o  (irq_req),
		.tmr0_rsp_i (tmr0_rsp),
		.tmr1_rsp_i (tmr1_rsp),
		.irq_rsp_i  (irq_rsp)
	);

	// ---------------------------------------------------------------------------
	// slaves
	// ---------------------------------------------------------------------------
	interval_timer timer0_inst (
		.clk             (clk),
		.reset           (reset),
		.bus_req_i       (tmr0_req),
		.bus_rsp_o       (tmr0_rsp),
		.interrupt_req_o (tmr_irq[0])
	);

	interval_timer timer1_inst (
		.clk             (clk),
		.reset           (reset),
		.bus_req_i       (tmr1_req),
		.bus_rsp_o       (tmr1_rsp),
		.interrupt_req_o (tmr_irq[1])
	);

	irq_controller irq_controller_inst (
		.clk         (clk),
		.reset       (reset),
		.src_pulse_i (tmr_irq),
		.bus_req_i   (irq_req),
		.bus_rsp_o   (irq_rsp),
		.irq_o       (irq_o)
	);

endmodule

//--- verification/timer_subsys_props.sv
/*
 * Bound assertions for the timer subsystem.
 * Ack exclusion and request hold on the arbiter,
 * irq_o after reset and pulse width on the interrupt controller.
 */

`timescale 1ns/100ps

`include "timer_defs.svh"

module timer_subsys_props
	import timer_pkg::*;
#(
	// set for the arbiter copy, clear for the interrupt controller copy
	parameter bit CHECK_ARB = 1'b1
)
(
	input logic                    clk,
	input logic                    reset,
	input wb_req_t                 req0_i,
	input wb_req_t                 req1_i,
	input logic                    ack0_i,
	input logic                    ack1_i,
	input logic                    irq_i,
	input logic [`IRQ_SOURCES-1:0] pulse_i
);

	// assertion failures of this copy
	int unsigned fail_count = 0;

	if (CHECK_ARB) begin : g_arb
		a_one_ack: assert property (@(posedge clk) disable iff (reset)
			!(ack0_i && ack1_i))
			else begin
				$error("two host acks in one cycle");
				fail_count++;
			end

		// a waiting master keeps its request until ack
		a_hold0: assert property (@(posedge clk) disable iff (reset)
			(req0_i.stb && !ack0_i) |=> (req0_i.stb && $stable(req0_i)))
			else begin
				$error("host 0 request changed before its ack");
				fail_count++;
			end

		a_hold1: assert property (@(posedge clk) disable iff (reset)
			(req1_i.stb && !ack1_i) |=> (req1_i.stb && $stable(req1_i)))
			else begin
				$error("host 1 request changed before its ack");
				fail_count++;
			end
	end else begin : g_irq
		a_irq_reset: assert property (@(posedge clk) reset |=> !irq_i)
			else begin
				$error("irq_o high in the cycle after reset");
				fail_count++;
			end

		for (genvar i = 0; i < `IRQ_SOURCES; i++) begin : g_pulse
			a_pulse_width: assert property (@(posedge clk) disable iff (reset)
				pulse_i[i] |=> !pulse_i[i])
				else begin
					$error("timer interrupt pulse longer than one cycle");
					fail_count++;
				end
		end
	end

endmodule

// unused inputs of each bound copy are tied low
bind wb_arbiter timer_subsys_props #(.CHECK_ARB(1'b1)) arb_props_inst (
	.clk     (clk),
	.reset   (reset),
	.req0_i  (host0_req_i),
	.req1_i  (host1_req_i),
	.ack0_i  (host0_rsp_o.ack),
	.ack1_i  (host1_rsp_o.ack),
	.irq_i   (1'b0),
	.pulse_i ('0)
);

bind irq_controller timer_subsys_props #(.CHECK_ARB(1'b0)) irq_props_inst (
	.clk     (clk),
	.reset   (reset),
	.req0_i  ('0),
	.req1_i  ('0),
	.ack0_i  (1'b0),
	.ack1_i  (1'b0),
	.irq_i   (irq_o),
	.pulse_i (src_pulse_i)
);

//--- verification/timer_subsys_tb.sv
/*
 * Testbench for the timer subsystem.
 * Clock, reset, LFSR stimulus on both host ports, register model
 * with a reference read function, read checker and cycle timeout.
 */

`timescale 1ns/100ps

`include "timer_defs.svh"

module timer_subsys_tb
	import timer_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int MAX_CYCLES = 4000;

	logic    clk;
	logic    reset;
	wb_req_t host_req [2];
	wb_rsp_t host_rsp [2];
	logic    irq;

	// register model
	logic        tmr_en [2];
	logic [31:0] tmr_cmp [2];
	logic [1:0]  irq_en_m;
	logic [1:0]  pending_m;

	logic        check_rd [2];
	logic [15:0] lfsr_state;
	int          errors;
	int          cycles;
	logic        arb_phase;
	logic        arb_seen;
	logic        last_ack;

	timer_subsys_top timer_subsys_top_inst (
		.clk         (clk),
		.reset       (reset),
		.host0_req_i (host_req[0]),
		.host1_req_i (host_req[1]),
		.host0_rsp_o (host_rsp[0]),
		.host1_rsp_o (host_rsp[1]),
		.irq_o       (irq)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
		end
		return v;
	endfunction

	function automatic logic [31:0] expected_read(input logic [3:0] adr);
		logic [31:0] v;
		v = '0;
		case (adr[3:2])
			`SLV_TIMER0, `SLV_TIMER1: begin
				if (adr[1:0] == CONTROL)
					v = {31'b0, tmr_en[adr[2]]};
				else if (adr[1:0] == COMPARE)
					v = tmr_cmp[adr[2]];
			end
			`SLV_IRQ: begin
				if (adr[1:0] == PENDING)
					v[1:0] = pending_m;
				else if (adr[1:0] == ENABLE)
					v[1:0] = irq_en_m;
			end
			default: v = '0;
		endcase
		return v;
	endfunction

	task automatic model_write(input logic [3:0] adr, input logic [31:0] dat);
		case (adr[3:2])
			`SLV_TIMER0, `SLV_TIMER1: begin
				if (adr[1:0] == CONTROL)
					tmr_en[adr[2]] = dat[0];
				else if (adr[1:0] == COMPARE)
					tmr_cmp[adr[2]] = dat;
			end
			`SLV_IRQ: begin
				if (adr[1:0] == PENDING)
					pending_m = pending_m & ~dat[1:0];
				else if (adr[1:0] == ENABLE)
					irq_en_m = dat[1:0];
			end
			default: ;
		endcase
	endtask

	task automatic report_fail(input string name, input logic [31:0] got, input logic [31:0] exp);
		errors++;
		$display("Fail %s got 0x%h expected 0x%h", name, got, exp);
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("Error: %s", msg);
	endtask

	// called 2 ns after a rising edge and returns at the same point
	task automatic bus_xfer(input int host, input logic [3:0] adr, input logic we,
			input logic [31:0] dat, input logic check, output logic [31:0] rdat);
		check_rd[host] = check && !we;
		host_req[host] = '{adr: adr, dat: dat, we: we, sel: '1, stb: 1'b1};
		do
			@(negedge clk);
		while (!host_rsp[host].ack);
		rdat = host_rsp[host].dat;
		if (we)
			model_write(adr, dat);
		@(posedge clk);
		#2;
		host_req[host] = '0;
	endtask

	task automatic wait_irq_rise(output time t);
		do
			@(negedge clk);
		while (irq);
		do
			@(negedge clk);
		while (!irq);
		t = $time;
		@(posedge clk);
		#2;
	endtask

	// ------------------------------------------------------------------------
	// read checker and arbitration order
	// ------------------------------------------------------------------------
	always @(negedge clk) begin
		if (!reset) begin
			for (int h = 0; h < 2; h++) begin
				if (host_rsp[h].ack && check_rd[h])
					assert (host_rsp[h].dat == expected_read(host_req[h].adr))
					else report_fail($sformatf("host%0d_rsp_o.dat", h), host_rsp[h].dat,
						expected_read(host_req[h].adr));
			end
			if (arb_phase && (host_rsp[0].ack || host_rsp[1].ack)) begin
				// host 1 takes the first tie and the acks then alternate
				assert (arb_seen ? (host_rsp[1].ack != last_ack) : host_rsp[1].ack)
				else report_error("host acks did not alternate");
				arb_seen = 1'b1;
				last_ack = host_rsp[1].ack;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", cycles);
			$display("errors: %0d", errors);
			$display("Test failed");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------
	initial begin
		logic [31:0] rdat;
		logic [31:0] rd0;
		logic [31:0] rd1;
		logic [31:0] v1;
		logic [31:0] v2;
		logic [31:0] cval;
		logic [31:0] cmp0 [4];
		logic [31:0] cmp1 [4];
		time         t_rise [3];

		reset = 1'b1;
		lfsr_state = 16'd59;
		errors = 0;
		cycles = 0;
		arb_phase = 1'b0;
		arb_seen = 1'b0;
		last_ack = 1'b0;
		irq_en_m = '0;
		pending_m = '0;
		for (int h = 0; h < 2; h++) begin
			host_req[h] = '0;
			check_rd[h] = 1'b0;
			tmr_en[h] = 1'b0;
			tmr_cmp[h] = `TIMER_COMPARE_RESET;
		end
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;
		assert (!host_rsp[0].ack && !host_rsp[1].ack && !irq)
		else report_error("host ack or irq_o high after reset");

		// reset values read by host 0 alone so host 1 wins the first tie
		for (int a = 0; a < 12; a++) begin
			if (a % 4 < 2)
				bus_xfer(0, a[3:0], 1'b0, 32'h0, 1'b1, rdat);
		end
		assert (!irq) else report_error("irq_o high after reset reads");

		// both hosts back to back on their own timer
		for (int k = 0; k < 4; k++) begin
			cmp0[k] = 32'h1000 + random_bits(12);
			cmp1[k] = 32'h1000 + random_bits(12);
		end
		arb_phase = 1'b1;
		fork
			for (int k = 0; k < 4; k++) begin
				bus_xfer(0, 4'h1, 1'b1, cmp0[k], 1'b0, rd0);
				bus_xfer(0, 4'h1, 1'b0, 32'h0, 1'b1, rd0);
			end
			for (int k = 0; k < 4; k++) begin
				bus_xfer(1, 4'h5, 1'b1, cmp1[k], 1'b0, rd1);
				bus_xfer(1, 4'h5, 1'b0, 32'h0, 1'b1, rd1);
			end
		join
		arb_phase = 1'b0;

		// random register writes read back from the other host
		for (int i = 0; i < 4; i++) begin
			cval = 32'h1000 + random_bits(20);
			bus_xfer(i % 2, {1'b0, i[1], 2'd1}, 1'b1, cval, 1'b0, rdat);
			bus_xfer(i % 2, {1'b0, i[1], 2'd0}, 1'b1, random_bits(1), 1'b0, rdat);
			bus_xfer(i % 2, 4'h9, 1'b1, random_bits(2), 1'b0, rdat);
			for (int r = 0; r < 4; r++)
				bus_xfer(1 - i % 2, {1'b0, i[1], r[1:0]}, 1'b0, 32'h0, r != 3, rdat);
			bus_xfer(1 - i % 2, 4'h9, 1'b0, 32'h0, 1'b1, rdat);
			bus_xfer(i % 2, {2'b11, 2'(random_bits(2))}, 1'b0, 32'h0, 1'b1, rdat);
		end
		bus_xfer(0, 4'h0, 1'b1, 32'h0, 1'b0, rdat);
		bus_xfer(0, 4'h4, 1'b1, 32'h0, 1'b0, rdat);

		// period between irq_o rises with pending cleared after each one
		for (int n = 0; n < 2; n++) begin
			cval = 32'd16 + random_bits(4);
			bus_xfer(0, {1'b0, n[0], 2'd1}, 1'b1, cval, 1'b0, rdat);
			bus_xfer(0, 4'h9, 1'b1, 32'd1 << n, 1'b0, rdat);
			bus_xfer(0, {1'b0, n[0], 2'd0}, 1'b1, 32'd3, 1'b0, rdat);
			for (int p = 0; p < 3; p++) begin
				wait_irq_rise(t_rise[p]);
				bus_xfer(1, 4'h8, 1'b1, 32'd3, 1'b0, rdat);
				bus_xfer(1, {1'b0, n[0], 2'd3}, 1'b0, 32'h0, 1'b0, rdat);
				assert (rdat <= cval) else report_fail("counter", rdat, cval);
			end
			// the clear ends well inside a period, so rises repeat every C+1 cycles
			for (int p = 1; p < 3; p++)
				assert ((t_rise[p] - t_rise[p-1]) / CLK_PERIOD == cval + 1)
				else report_fail("irq_o period",
					32'((t_rise[p] - t_rise[p-1]) / CLK_PERIOD), cval + 1);
			bus_xfer(0, {1'b0, n[0], 2'd0}, 1'b1, 32'd0, 1'b0, rdat);
		end
		repeat (4) @(posedge clk);
		#2;
		bus_xfer(0, 4'h8, 1'b1, 32'd3, 1'b0, rdat);

		// masked timer 1 only sets pending
		bus_xfer(0, 4'h9, 1'b1, 32'd1, 1'b0, rdat);
		bus_xfer(0, 4'h5, 1'b1, 32'd12, 1'b0, rdat);
		bus_xfer(0, 4'h4, 1'b1, 32'd3, 1'b0, rdat);
		repeat (20) begin
			@(negedge clk);
			assert (!irq) else report_error("irq_o raised by a masked source");
		end
		@(posedge clk);
		#2;
		bus_xfer(0, 4'h4, 1'b1, 32'd0, 1'b0, rdat);
		pending_m = 2'b10;
		bus_xfer(1, 4'h8, 1'b0, 32'h0, 1'b1, rdat);

		// enabled timer 0 raises irq_o and a write of one to pending drops it
		bus_xfer(0, 4'h1, 1'b1, 32'd10, 1'b0, rdat);
		bus_xfer(0, 4'h0, 1'b1, 32'd3, 1'b0, rdat);
		wait_irq_rise(t_rise[0]);
		bus_xfer(0, 4'h0, 1'b1, 32'd0, 1'b0, rdat);
		pending_m = 2'b11;
		bus_xfer(1, 4'h8, 1'b0, 32'h0, 1'b1, rdat);
		bus_xfer(1, 4'h8, 1'b1, 32'd1, 1'b0, rdat);
		repeat (2) @(negedge clk);
		assert (!irq) else report_error("irq_o still high after pending clear");
		@(posedge clk);
		#2;
		bus_xfer(1, 4'h8, 1'b1, 32'd2, 1'b0, rdat);
		bus_xfer(1, 4'h8, 1'b0, 32'h0, 1'b1, rdat);

		// clear bit restarts the counter and reads back low
		bus_xfer(0, 4'h1, 1'b1, 32'd1000, 1'b0, rdat);
		bus_xfer(0, 4'h0, 1'b1, 32'd3, 1'b0, rdat);
		repeat (30) @(posedge clk);
		#2;
		bus_xfer(1, 4'h3, 1'b0, 32'h0, 1'b0, v1);
		bus_xfer(1, 4'h0, 1'b1, 32'd3, 1'b0, rdat);
		bus_xfer(1, 4'h3, 1'b0, 32'h0, 1'b0, v2);
		assert (v2 < v1) else report_fail("counter after clear", v2, v1);
		bus_xfer(1, 4'h0, 1'b0, 32'h0, 1'b1, rdat);
		assert (!rdat[1]) else report_fail("control", rdat, 32'h1);
		bus_xfer(0, 4'h0, 1'b1, 32'd0, 1'b0, rdat);

		errors += timer_subsys_top_inst.wb_arbiter_inst.arb_props_inst.fail_count;
		errors += timer_subsys_top_inst.irq_controller_inst.irq_props_inst.fail_count;
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- timer_subsys.f
+incdir+include
hw/timer_pkg.sv
hw/wb_arbiter.sv
hw/periph_decoder.sv
hw/interval_timer.sv
hw/irq_controller.sv
hw/timer_subsys_top.sv
verification/timer_subsys_props.sv
verification/timer_subsys_tb.sv
